/* design/rv_alu.sv */
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module rv_alu (
    input  rv_exec_pkg::alu_op_e alu_op,
    input  logic [`RV_XLEN-1:0]  src1,
    input  logic [`RV_XLEN-1:0]  src2,
    input  logic                 word_op,
    output logic [`RV_XLEN-1:0]  alu_res,
    output logic                 cond
);

    logic [5:0]          shamt;
    logic [`RV_XLEN-1:0] srl_src;
    logic [`RV_XLEN-1:0] sra_src;

    // word shifts see only the low half and a 5-bit amount
    assign shamt   = word_op ? {1'b0, src2[4:0]} : src2[5:0];
    assign srl_src = word_op ? {{(`RV_XLEN-32){1'b0}}, src1[31:0]} : src1;
    assign sra_src = word_op ? {{(`RV_XLEN-32){src1[31]}}, src1[31:0]} : src1;

    always_comb begin
        alu_res = '0;
        cond    = 1'b0;
        case (alu_op)
            rv_exec_pkg::ALU_ADD:  alu_res = src1 + src2;
            rv_exec_pkg::ALU_SUB:  alu_res = src1 - src2;
            rv_exec_pkg::ALU_AND:  alu_res = src1 & src2;
            rv_exec_pkg::ALU_OR:   alu_res = src1 | src2;
            rv_exec_pkg::ALU_XOR:  alu_res = src1 ^ src2;
            rv_exec_pkg::ALU_SLT: begin
                alu_res = {{(`RV_XLEN-1){1'b0}}, ($signed(src1) < $signed(src2))};
            end
            rv_exec_pkg::ALU_SLTU: begin
                alu_res = {{(`RV_XLEN-1){1'b0}}, (src1 < src2)};
            end
            rv_exec_pkg::ALU_SLL:  alu_res = src1 << shamt;     // upper half fixed by ext
            rv_exec_pkg::ALU_SRL:  alu_res = srl_src >> shamt;
            rv_exec_pkg::ALU_SRA:  alu_res = $unsigned($signed(sra_src) >>> shamt);
            rv_exec_pkg::ALU_MUL:  alu_res = src1 * src2;       // low 64 bits
            rv_exec_pkg::ALU_DIVU: begin
                alu_res = (src2 == '0) ? '1 : src1 / src2;
            end
            rv_exec_pkg::ALU_REMU: begin
                alu_res = (src2 == '0) ? src1 : src1 % src2;
            end
            rv_exec_pkg::ALU_BEQ:  cond = (src1 == src2);
            rv_exec_pkg::ALU_BNE:  cond = (src1 != src2);
            rv_exec_pkg::ALU_BLT:  cond = ($signed(src1) < $signed(src2));
            rv_exec_pkg::ALU_BGE:  cond = ($signed(src1) >= $signed(src2));
            rv_exec_pkg::ALU_BLTU: cond = (src1 < src2);
            rv_exec_pkg::ALU_BGEU: cond = (src1 >= src2);
            default: ;
        endcase
    end

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module rv_decoder (
    input  logic [31:0]              instr,
    output logic [`RV_REG_IDX_W-1:0] rs1_addr,
    output logic [`RV_REG_IDX_W-1:0] rs2_addr,
    output logic [`RV_REG_IDX_W-1:0] rd_addr,
    output logic [`RV_XLEN-1:0]      imm,
    output rv_exec_pkg::alu_op_e     alu_op,
    output logic                     use_imm,
    output logic                     word_op,
    output logic                     writes_rd,
    output logic                     is_branch,
    output logic                     illegal,
    output rv_exec_pkg::ext_mode_e   ext_mode
);

    rv_isa_pkg::instr_u iw;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign iw       = instr;
    assign opcode   = iw.r.opcode;
    assign funct3   = iw.r.funct3;
    assign funct7   = iw.r.funct7;
    assign rs1_addr = iw.r.rs1;
    assign rs2_addr = iw.b.rs2;     // same bits in R and B
    assign rd_addr  = iw.r.rd;

    // branch offset from the B view, everything else from the I view
    always_comb begin
        if (opcode == rv_isa_pkg::OPC_BRANCH) begin
            imm = {{(`RV_XLEN-12){iw.b.imm12}}, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
        end else begin
            imm = {{(`RV_XLEN-12){iw.i.imm12[11]}}, iw.i.imm12};
        end
    end

    always_comb begin
        alu_op    = rv_exec_pkg::ALU_ADD;
        use_imm   = 1'b0;
        word_op   = 1'b0;
        writes_rd = 1'b1;
        is_branch = 1'b0;
        illegal   = 1'b0;
        ext_mode  = rv_exec_pkg::EXT_FULL;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = rv_exec_pkg::ALU_ADD;
                    {7'b0000000, 3'b001}: alu_op = rv_exec_pkg::ALU_SLL;
                    {7'b0000000, 3'b010}: alu_op = rv_exec_pkg::ALU_SLT;
                    {7'b0000000, 3'b011}: alu_op = rv_exec_pkg::ALU_SLTU;
                    {7'b0000000, 3'b100}: alu_op = rv_exec_pkg::ALU_XOR;
                    {7'b0000000, 3'b101}: alu_op = rv_exec_pkg::ALU_SRL;
                    {7'b0000000, 3'b110}: alu_op = rv_exec_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: alu_op = rv_exec_pkg::ALU_AND;
                    {rv_isa_pkg::F7_ALT, 3'b000}:    alu_op = rv_exec_pkg::ALU_SUB;
                    {rv_isa_pkg::F7_ALT, 3'b101}:    alu_op = rv_exec_pkg::ALU_SRA;
                    {rv_isa_pkg::F7_MULDIV, 3'b000}: alu_op = rv_exec_pkg::ALU_MUL;
                    {rv_isa_pkg::F7_MULDIV, 3'b101}: alu_op = rv_exec_pkg::ALU_DIVU;
                    {rv_isa_pkg::F7_MULDIV, 3'b111}: alu_op = rv_exec_pkg::ALU_REMU;
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    3'b000: alu_op = rv_exec_pkg::ALU_ADD;
                    3'b010: alu_op = rv_exec_pkg::ALU_SLT;
                    3'b011: alu_op = rv_exec_pkg::ALU_SLTU;
                    3'b100: alu_op = rv_exec_pkg::ALU_XOR;
                    3'b110: alu_op = rv_exec_pkg::ALU_OR;
                    3'b111: alu_op = rv_exec_pkg::ALU_AND;
                    3'b001: begin                   // imm[11:6] must be zero
                        alu_op  = rv_exec_pkg::ALU_SLL;
                        illegal = (funct7[6:1] != 6'b0);
                    end
                    default: begin                  // 101, srli or srai
                        if (funct7[6:1] == 6'b0) begin
                            alu_op = rv_exec_pkg::ALU_SRL;
                        end else if (funct7[6:1] == rv_isa_pkg::F7_ALT[6:1]) begin
                            alu_op = rv_exec_pkg::ALU_SRA;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            rv_isa_pkg::OPC_OP_32: begin
                word_op  = 1'b1;
                ext_mode = rv_exec_pkg::EXT_WORD;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}:         alu_op = rv_exec_pkg::ALU_ADD;
                    {7'b0000000, 3'b001}:         alu_op = rv_exec_pkg::ALU_SLL;
                    {7'b0000000, 3'b101}:         alu_op = rv_exec_pkg::ALU_SRL;
                    {rv_isa_pkg::F7_ALT, 3'b000}: alu_op = rv_exec_pkg::ALU_SUB;
                    {rv_isa_pkg::F7_ALT, 3'b101}: alu_op = rv_exec_pkg::ALU_SRA;
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM_32: begin
                use_imm  = 1'b1;
                word_op  = 1'b1;
                ext_mode = rv_exec_pkg::EXT_WORD;
                case ({(funct3 == 3'b000) ? 7'b0 : funct7, funct3})   // addiw ignores funct7
                    {7'b0000000, 3'b000}:         alu_op = rv_exec_pkg::ALU_ADD;
                    {7'b0000000, 3'b001}:         alu_op = rv_exec_pkg::ALU_SLL;
                    {7'b0000000, 3'b101}:         alu_op = rv_exec_pkg::ALU_SRL;
                    {rv_isa_pkg::F7_ALT, 3'b101}: alu_op = rv_exec_pkg::ALU_SRA;
                    default: illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::OPC_BRANCH: begin
                writes_rd = 1'b0;
                is_branch = 1'b1;
                case (funct3)
                    3'b000:  alu_op = rv_exec_pkg::ALU_BEQ;
                    3'b001:  alu_op = rv_exec_pkg::ALU_BNE;
                    3'b100:  alu_op = rv_exec_pkg::ALU_BLT;
                    3'b101:  alu_op = rv_exec_pkg::ALU_BGE;
                    3'b110:  alu_op = rv_exec_pkg::ALU_BLTU;
                    3'b111:  alu_op = rv_exec_pkg::ALU_BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            writes_rd = 1'b0;   // illegal ops have no side effect
            is_branch = 1'b0;
        end
    end

endmodule

/* design/rv_exec_pkg.sv */
package rv_exec_pkg;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_AND  = 5'd2,
        ALU_OR   = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_SLT  = 5'd5,
        ALU_SLTU = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8,
        ALU_SRA  = 5'd9,
        ALU_MUL  = 5'd10,
        ALU_DIVU = 5'd11,
        ALU_REMU = 5'd12,
        ALU_BEQ  = 5'd16,   // compares grouped from 16 up
        ALU_BNE  = 5'd17,
        ALU_BLT  = 5'd18,
        ALU_BGE  = 5'd19,
        ALU_BLTU = 5'd20,
        ALU_BGEU = 5'd21
    } alu_op_e;

    // how the result stage widens the alu output
    typedef enum logic {
        EXT_FULL = 1'b0,
        EXT_WORD = 1'b1
    } ext_mode_e;

endpackage

/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;     // imm[11:0], shamt lives in the low bits
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic        imm12;     // sign bit of the offset
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } b_fmt_t;

    // one instruction word, three ways to look at it
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] F7_ALT        = 7'b0100000;  // sub / sra
    localparam logic [6:0] F7_MULDIV     = 7'b0000001;  // M extension

endpackage

/* design/rv_regfile.sv */
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module rv_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`RV_REG_IDX_W-1:0] rs1_addr,
    input  logic [`RV_REG_IDX_W-1:0] rs2_addr,
    output logic [`RV_XLEN-1:0]      rs1_data,
    output logic [`RV_XLEN-1:0]      rs2_data,
    input  logic                     wr_en,
    input  logic [`RV_REG_IDX_W-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]      wr_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin     // x0 writes dropped
            regs[wr_addr] <= wr_data;
        end
    end

    // async read, x0 hardwired
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* design/rv_result.sv */
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module rv_result (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic [`RV_XLEN-1:0]      alu_res,
    input  logic                     cond,
    input  logic [`RV_REG_IDX_W-1:0] rd_addr_in,
    input  rv_exec_pkg::ext_mode_e   ext_mode,
    input  logic                     writes_rd,
    input  logic                     is_branch,
    input  logic                     illegal_in,
    input  logic [`RV_XLEN-1:0]      pc,
    input  logic [`RV_XLEN-1:0]      imm,
    output logic                     wr_en,
    output logic [`RV_REG_IDX_W-1:0] wr_addr,
    output logic [`RV_XLEN-1:0]      wr_data,
    output logic                     result_valid,
    output logic [`RV_REG_IDX_W-1:0] rd_addr,
    output logic [`RV_XLEN-1:0]      rd_data,
    output logic                     branch_valid,
    output logic                     branch_taken,
    output logic [`RV_XLEN-1:0]      branch_target,
    output logic                     illegal
);

    logic [`RV_XLEN-1:0] res_ext;

    always_comb begin
        case (ext_mode)
            rv_exec_pkg::EXT_WORD: res_ext = {{(`RV_XLEN-32){alu_res[31]}}, alu_res[31:0]};
            default:               res_ext = alu_res;
        endcase
    end

    // regfile write lands on the same edge as the output register
    assign wr_en   = instr_valid & writes_rd;
    assign wr_addr = rd_addr_in;
    assign wr_data = res_ext;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            branch_valid <= 1'b0;
            branch_taken <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            result_valid <= wr_en;                          // one-cycle pulses
            branch_valid <= instr_valid & is_branch;
            branch_taken <= instr_valid & is_branch & cond;
            illegal      <= instr_valid & illegal_in;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            rd_addr       <= rd_addr_in;
            rd_data       <= res_ext;
            branch_target <= pc + imm;  // imm is the B offset on branches
        end
    end

endmodule

/* design/rvseed_defines.svh */
`ifndef RVSEED_DEFINES_SVH
`define RVSEED_DEFINES_SVH

// datapath width of the core
`define RV_XLEN 64

// integer register file size
`define RV_REG_COUNT 32

// index width to address RV_REG_COUNT registers
`define RV_REG_IDX_W 5

`endif

/* design/rvseed_exec_core.sv */
`timescale 1ns/100ps
`include "rvseed_defines.svh"

module rvseed_exec_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [`RV_XLEN-1:0]      pc,
    output logic                     result_valid,
    output logic [`RV_REG_IDX_W-1:0] rd_addr,
    output logic [`RV_XLEN-1:0]      rd_data,
    output logic                     branch_valid,
    output logic                     branch_taken,
    output logic [`RV_XLEN-1:0]      branch_target,
    output logic                     illegal
);

    logic [`RV_REG_IDX_W-1:0] rs1_addr;
    logic [`RV_REG_IDX_W-1:0] rs2_addr;
    logic [`RV_REG_IDX_W-1:0] dec_rd_addr;
    logic [`RV_XLEN-1:0]      rs1_data;
    logic [`RV_XLEN-1:0]      rs2_data;
    logic [`RV_XLEN-1:0]      imm;
    logic [`RV_XLEN-1:0]      src2;
    logic [`RV_XLEN-1:0]      alu_res;
    rv_exec_pkg::alu_op_e     alu_op;
    rv_exec_pkg::ext_mode_e   ext_mode;
    logic                     use_imm;
    logic                     word_op;
    logic                     writes_rd;
    logic                     is_branch;
    logic                     dec_illegal;
    logic                     cond;
    logic                     wr_en;
    logic [`RV_REG_IDX_W-1:0] wr_addr;
    logic [`RV_XLEN-1:0]      wr_data;

    rv_decoder u_decode (
        .instr     (instr),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rd_addr   (dec_rd_addr),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .word_op   (word_op),
        .writes_rd (writes_rd),
        .is_branch (is_branch),
        .illegal   (dec_illegal),
        .ext_mode  (ext_mode)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // second operand, immediate forms take imm
    assign src2 = use_imm ? imm : rs2_data;

    rv_alu u_execute (
        .alu_op  (alu_op),
        .src1    (rs1_data),
        .src2    (src2),
        .word_op (word_op),
        .alu_res (alu_res),
        .cond    (cond)
    );

    rv_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .alu_res       (alu_res),
        .cond          (cond),
        .rd_addr_in    (dec_rd_addr),
        .ext_mode      (ext_mode),
        .writes_rd     (writes_rd),
        .is_branch     (is_branch),
        .illegal_in    (dec_illegal),
        .pc            (pc),
        .imm           (imm),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .result_valid  (result_valid),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal       (illegal)
    );

endmodule

/* dv/rvseed_exec_tb.sv */
`timescale 1ns/100ps

module rvseed_exec_tb;

    localparam int K_NONE    = 0;
    localparam int K_WRITE   = 1;
    localparam int K_BRANCH  = 2;
    localparam int K_ILLEGAL = 3;

    // model operation codes 0..6 form the plain alu group
    localparam int O_ADD  = 0;
    localparam int O_SUB  = 1;
    localparam int O_AND  = 2;
    localparam int O_OR   = 3;
    localparam int O_XOR  = 4;
    localparam int O_SLT  = 5;
    localparam int O_SLTU = 6;
    localparam int O_SLL  = 7;
    localparam int O_SRL  = 8;
    localparam int O_SRA  = 9;
    localparam int O_MUL  = 10;
    localparam int O_DIVU = 11;
    localparam int O_REMU = 12;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [63:0] pc;
    logic        result_valid;
    logic [4:0]  rd_addr;
    logic [63:0] rd_data;
    logic        branch_valid;
    logic        branch_taken;
    logic [63:0] branch_target;
    logic        illegal;

    logic [63:0] regs_m [32];   // architectural state of the model
    int          pend_kind;
    int          chk_kind;
    logic [4:0]  pend_rd;
    logic [4:0]  chk_rd;
    logic [63:0] pend_data;
    logic [63:0] chk_data;
    logic        pend_taken;
    logic        chk_taken;
    logic [63:0] pend_target;
    logic [63:0] chk_target;
    int          err_cnt = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic        hung = 1'b0;
    string       test_name [6] = '{"alu_logic", "shifts", "muldiv", "branches",
                                   "x0_and_forwarding", "illegal"};

    rvseed_exec_core i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .pc            (pc),
        .result_valid  (result_valid),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .branch_valid  (branch_valid),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // expected response lags the strobe by one edge like the DUT
    always @(posedge clk) begin
        if (!rst_n) begin
            chk_kind <= K_NONE;
        end else begin
            chk_kind   <= instr_valid ? pend_kind : K_NONE;
            chk_rd     <= pend_rd;
            chk_data   <= pend_data;
            chk_taken  <= pend_taken;
            chk_target <= pend_target;
        end
    end

    task automatic log_mismatch(input string sig, input logic [63:0] got, input logic [63:0] exp);
        $display("error at %0t: %s got %h expected %h", $time, sig, got, exp);
        err_cnt++;
    endtask

    a_result_valid: assert property (@(negedge clk) disable iff (!rst_n)
        result_valid == (chk_kind == K_WRITE))
        else log_mismatch("result_valid", 64'(result_valid), 64'(chk_kind == K_WRITE));
    a_rd_addr: assert property (@(negedge clk) disable iff (!rst_n)
        (chk_kind == K_WRITE) |-> rd_addr == chk_rd)
        else log_mismatch("rd_addr", 64'(rd_addr), 64'(chk_rd));
    a_rd_data: assert property (@(negedge clk) disable iff (!rst_n)
        (chk_kind == K_WRITE) |-> rd_data == chk_data)
        else log_mismatch("rd_data", rd_data, chk_data);
    a_branch_valid: assert property (@(negedge clk) disable iff (!rst_n)
        branch_valid == (chk_kind == K_BRANCH))
        else log_mismatch("branch_valid", 64'(branch_valid), 64'(chk_kind == K_BRANCH));
    a_branch_taken: assert property (@(negedge clk) disable iff (!rst_n)
        (chk_kind == K_BRANCH) |-> branch_taken == chk_taken)
        else log_mismatch("branch_taken", 64'(branch_taken), 64'(chk_taken));
    a_branch_target: assert property (@(negedge clk) disable iff (!rst_n)
        (chk_kind == K_BRANCH) |-> branch_target == chk_target)
        else log_mismatch("branch_target", branch_target, chk_target);
    a_illegal: assert property (@(negedge clk) disable iff (!rst_n)
        illegal == (chk_kind == K_ILLEGAL))
        else log_mismatch("illegal", 64'(illegal), 64'(chk_kind == K_ILLEGAL));

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [4:0] pick_src();
        return 5'($urandom % 7);    // x0..x6
    endfunction

    function automatic logic [4:0] pick_dst();
        return 5'(7 + $urandom % 6);    // x7..x12 so loaded sources are never overwritten
    endfunction

    function automatic logic [2:0] f3_of(input int op);
        case (op)
            O_SLL:                return 3'b001;
            O_SLT:                return 3'b010;
            O_SLTU:               return 3'b011;
            O_XOR:                return 3'b100;
            O_SRL, O_SRA, O_DIVU: return 3'b101;
            O_OR:                 return 3'b110;
            O_AND, O_REMU:        return 3'b111;
            default:              return 3'b000;
        endcase
    endfunction

    function automatic logic [6:0] f7_of(input int op);
        case (op)
            O_SUB, O_SRA:          return rv_isa_pkg::F7_ALT;
            O_MUL, O_DIVU, O_REMU: return rv_isa_pkg::F7_MULDIV;
            default:               return 7'b0000000;
        endcase
    endfunction

    // word forms keep 32 bits and then sign-extend
    function automatic logic [63:0] model_alu(input int op, input logic [63:0] a,
                                              input logic [63:0] b, input logic word);
        logic [31:0] w;
        if (word) begin
            case (op)
                O_SUB:   w = a[31:0] - b[31:0];
                O_SLL:   w = a[31:0] << b[4:0];
                O_SRL:   w = a[31:0] >> b[4:0];
                O_SRA:   w = $signed(a[31:0]) >>> b[4:0];
                default: w = a[31:0] + b[31:0];
            endcase
            return {{32{w[31]}}, w};
        end
        case (op)
            O_ADD:   return a + b;
            O_SUB:   return a - b;
            O_AND:   return a & b;
            O_OR:    return a | b;
            O_XOR:   return a ^ b;
            O_SLT:   return {63'd0, $signed(a) < $signed(b)};
            O_SLTU:  return {63'd0, a < b};
            O_SLL:   return a << b[5:0];
            O_SRL:   return a >> b[5:0];
            O_SRA:   return $signed(a) >>> b[5:0];
            O_MUL:   return a * b;
            O_DIVU:  return (b == 64'd0) ? '1 : a / b;
            O_REMU:  return (b == 64'd0) ? a : a % b;
            default: return 64'd0;
        endcase
    endfunction

    // one strobe per call that returns on the next falling edge
    task automatic present(input logic [31:0] word, input int kind, input logic [4:0] rd,
                           input logic [63:0] data, input logic taken,
                           input logic [63:0] target, input logic [63:0] pc_val);
        instr_valid = 1'b1;
        instr       = word;
        pc          = pc_val;
        pend_kind   = kind;
        pend_rd     = rd;
        pend_data   = data;
        pend_taken  = taken;
        pend_target = target;
        if (kind == K_WRITE && rd != 5'd0) begin
            regs_m[rd] = data;
        end
        @(negedge clk);
    endtask

    task automatic issue_rr(input int op, input logic word, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] opc;
        opc = word ? rv_isa_pkg::OPC_OP_32 : rv_isa_pkg::OPC_OP;
        present({f7_of(op), rs2, rs1, f3_of(op), rd, opc}, K_WRITE, rd,
                model_alu(op, regs_m[rs1], regs_m[rs2], word), 1'b0, 64'd0, rand64());
    endtask

    task automatic issue_ri(input int op, input logic word, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [11:0] imm);
        logic [11:0] enc;
        logic [6:0]  opc;
        enc = imm;
        if (op == O_SRA) begin
            enc = {6'b010000, imm[5:0]};
        end else if (op == O_SLL || op == O_SRL) begin
            enc = {6'b000000, imm[5:0]};
        end
        opc = word ? rv_isa_pkg::OPC_OP_IMM_32 : rv_isa_pkg::OPC_OP_IMM;
        present({enc, rs1, f3_of(op), rd, opc}, K_WRITE, rd,
                model_alu(op, regs_m[rs1], {{52{enc[11]}}, enc}, word), 1'b0, 64'd0, rand64());
    endtask

    task automatic issue_br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                            input logic [12:0] off);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] pc_val;
        logic        taken;
        a      = regs_m[rs1];
        b      = regs_m[rs2];
        pc_val = rand64() & ~64'h3;
        case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            default: taken = (a >= b);
        endcase
        present({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH},
                K_BRANCH, 5'd0, 64'd0, taken, pc_val + {{51{off[12]}}, off}, pc_val);
    endtask

    // addi from x0 and then five rounds of slli 11 and ori
    task automatic load_reg(input logic [4:0] rd, input logic [63:0] val);
        issue_ri(O_ADD, 1'b0, rd, 5'd0, {3'b000, val[63:55]});
        for (int k = 4; k >= 0; k--) begin
            issue_ri(O_SLL, 1'b0, rd, rd, 12'd11);
            issue_ri(O_OR, 1'b0, rd, rd, {1'b0, val[k*11 +: 11]});
        end
    endtask

    task automatic load_sources();
        for (int r = 1; r <= 6; r++) begin
            load_reg(5'(r), rand64());
        end
    endtask

    task automatic check_alu_logic();
        int op;
        load_sources();
        for (int n = 0; n < 40; n++) begin
            op = int'($urandom % 7);
            issue_rr(op, 1'b0, pick_dst(), pick_src(), pick_src());
            if (op != O_SUB) begin  // no subi
                issue_ri(op, 1'b0, pick_dst(), pick_src(), 12'($urandom));
            end
        end
    endtask

    task automatic check_shifts();
        load_sources();
        for (int n = 0; n < 12; n++) begin
            for (int op = O_SLL; op <= O_SRA; op++) begin
                issue_rr(op, 1'b0, pick_dst(), pick_src(), pick_src());
                issue_rr(op, 1'b1, pick_dst(), pick_src(), pick_src());
                issue_ri(op, 1'b0, pick_dst(), pick_src(), 12'($urandom % 64));
                issue_ri(op, 1'b1, pick_dst(), pick_src(), 12'($urandom % 32));
            end
            issue_rr(O_ADD, 1'b1, pick_dst(), pick_src(), pick_src());
            issue_rr(O_SUB, 1'b1, pick_dst(), pick_src(), pick_src());
            issue_ri(O_ADD, 1'b1, pick_dst(), pick_src(), 12'($urandom));
        end
    endtask

    task automatic check_muldiv();
        load_sources();
        load_reg(5'd5, 64'(1 + $urandom % 1000));  // small divisor
        for (int n = 0; n < 10; n++) begin
            for (int op = O_MUL; op <= O_REMU; op++) begin
                issue_rr(op, 1'b0, pick_dst(), pick_src(), pick_src());
            end
        end
        issue_rr(O_DIVU, 1'b0, 5'd7, 5'd1, 5'd0);
        issue_rr(O_REMU, 1'b0, 5'd8, 5'd1, 5'd0);
    endtask

    task automatic check_branches();
        logic [2:0] f3;
        load_sources();
        for (int n = 0; n < 48; n++) begin
            f3 = 3'(n % 6);
            f3 = (f3 < 3'd2) ? f3 : f3 + 3'd2;  // skip the two reserved codes
            issue_br(f3, pick_src(), pick_src(), {12'($urandom), 1'b0});
            issue_br(f3, 5'(1 + n % 6), 5'(1 + n % 6), {12'($urandom), 1'b0});
        end
    endtask

    task automatic check_x0_forwarding();
        load_sources();
        issue_ri(O_ADD, 1'b0, 5'd0, 5'd0, 12'h123);
        issue_rr(O_ADD, 1'b0, 5'd7, 5'd0, 5'd0);
        issue_rr(O_OR, 1'b0, 5'd0, 5'd1, 5'd2);
        issue_rr(O_ADD, 1'b0, 5'd8, 5'd0, 5'd3);
        for (int n = 0; n < 10; n++) begin
            issue_ri(O_ADD, 1'b0, 5'd7, 5'd7, 12'($urandom));
            issue_rr(O_XOR, 1'b0, 5'd8, 5'd7, 5'd1);
            issue_rr(O_ADD, 1'b0, 5'd7, 5'd8, 5'd7);
        end
    endtask

    task automatic check_illegal();
        load_reg(5'd3, rand64());
        // load, div, branch funct3 010 and slliw with shamt bit 5
        present({12'h010, 5'd2, 3'b011, 5'd3, 7'b0000011},
                K_ILLEGAL, 5'd3, 64'd0, 1'b0, 64'd0, 64'd0);
        present({rv_isa_pkg::F7_MULDIV, 5'd1, 5'd2, 3'b100, 5'd3, rv_isa_pkg::OPC_OP},
                K_ILLEGAL, 5'd3, 64'd0, 1'b0, 64'd0, 64'd0);
        present({7'd0, 5'd1, 5'd2, 3'b010, 5'd3, rv_isa_pkg::OPC_BRANCH},
                K_ILLEGAL, 5'd3, 64'd0, 1'b0, 64'd0, 64'd0);
        present({7'b0000001, 5'd1, 5'd2, 3'b001, 5'd3, rv_isa_pkg::OPC_OP_IMM_32},
                K_ILLEGAL, 5'd3, 64'd0, 1'b0, 64'd0, 64'd0);
        issue_rr(O_ADD, 1'b0, 5'd7, 5'd3, 5'd0);    // x3 must be unchanged
    endtask

    // idle the strobe until every pulse has been seen
    task automatic drain();
        int n;
        n = 0;
        instr_valid = 1'b0;
        pend_kind   = K_NONE;
        while ((chk_kind != K_NONE || result_valid || branch_valid || illegal) && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) begin
            $display("timeout: outputs still active 20 cycles after the last instruction");
            hung = 1'b1;
        end
    endtask

    task automatic close_test(input int t, input int errs_before);
        if (err_cnt == errs_before && !hung) begin
            $display("test %0d %s passed", t, test_name[t-1]);
            tests_passed++;
        end else begin
            $display("test %0d %s failed with %0d check errors", t, test_name[t-1],
                     err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int errs;
        void'($urandom(21934));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        pc          = 64'd0;
        pend_kind   = K_NONE;
        pend_rd     = 5'd0;
        pend_data   = 64'd0;
        pend_taken  = 1'b0;
        pend_target = 64'd0;
        for (int r = 0; r < 32; r++) begin
            regs_m[r] = 64'd0;
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int t = 1; t <= 6 && !hung; t++) begin
            errs = err_cnt;
            case (t)
                1:       check_alu_logic();
                2:       check_shifts();
                3:       check_muldiv();
                4:       check_branches();
                5:       check_x0_forwarding();
                default: check_illegal();
            endcase
            drain();
            close_test(t, errs);
        end
        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 tests_passed, tests_failed, err_cnt);
        if (err_cnt == 0 && tests_failed == 0 && !hung) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_exec_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_result.sv
design/rvseed_exec_core.sv
dv/rvseed_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
if [ $? -ne 0 ]; then
    echo "could not clean the build directory"
    exit 1
fi

verilator --binary --timing --assert -f flist.f --top-module rvseed_exec_tb -o rvseed_exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/rvseed_exec_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation log has no final verdict"
    exit 1
fi
exit 0
